// ==== include/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address width
`define ADDR_WIDTH 32

// one cache block, 8 bytes
`define BLOCK_WIDTH 64

// load and store data width
`define WORD_WIDTH 32

// sets per way
`define N_SETS 16

// memory model response delay in cycles
`define MEM_LATENCY 3

`endif

// ==== hdl/cache_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    localparam int offset_bits = $clog2(`BLOCK_WIDTH / 8);
    localparam int index_bits = $clog2(`N_SETS);
    localparam int tag_bits = `ADDR_WIDTH - offset_bits - index_bits;

    typedef enum logic {
        READ = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // encoding 2'd3 is unused
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALFWORD = 2'd1,
        WORD = 2'd2
    } req_width_t;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`BLOCK_WIDTH-1:0] block_t;
    typedef logic [`ADDR_WIDTH-offset_bits-1:0] block_addr_t; // tag and index
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;

    // one tag array entry, valid bit on top
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== hdl/set_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// two ways side by side, one shared index
module set_ram #(
    parameter type entry_t = logic [7:0],
    parameter int depth = 16
) (
    input wire clk,
    input wire init,
    input wire en,                           // registered read of both ways
    input wire [$clog2(depth)-1:0] index,
    input wire [1:0] way_we,                 // one write enable per way
    input wire entry_t din,
    output entry_t dout0,
    output entry_t dout1
);

    entry_t mem [2][depth];

    // reads return the contents from before a write in the same cycle
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int w = 0; w < 2; w++) begin
                for (int i = 0; i < depth; i++) begin
                    mem[w][i] <= '0;         // clears the valid bits of the tag array
                end
            end
            dout0 <= '0;
            dout1 <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w]) begin
                    mem[w][index] <= din;
                end
            end
            if (en) begin
                dout0 <= mem[0][index];
                dout1 <= mem[1][index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/way_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_lfsr (
    input wire clk,
    input wire init,
    input wire step,        // one advance per refill
    output logic victim_bit
);

    localparam logic [7:0] seed = 8'hb5; // any nonzero value

    logic [7:0] lfsr;
    logic feedback;

    // taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            lfsr <= seed;
        end else if (step) begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    assign victim_bit = lfsr[7];

endmodule

`default_nettype wire

// ==== hdl/way_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_match (
    input wire cache_pkg::addr_t lat_addr,
    input wire cache_pkg::tag_entry_t tag_out0,
    input wire cache_pkg::tag_entry_t tag_out1,
    input wire cache_pkg::block_t data_out0,
    input wire cache_pkg::block_t data_out1,
    input wire victim_bit,
    output logic hit,
    output logic hit_way,
    output cache_pkg::block_t hit_block,
    output cache_pkg::word_t rd_word,
    output logic [1:0] fill_way_we
);

    cache_pkg::tag_t lat_tag;
    cache_pkg::offset_t lat_offset;
    logic sel0;
    logic sel1;

    assign lat_tag = lat_addr[$bits(cache_pkg::addr_t)-1 -: cache_pkg::tag_bits];
    assign lat_offset = lat_addr[cache_pkg::offset_bits-1:0];

    assign sel0 = tag_out0.valid && (tag_out0.tag == lat_tag);
    assign sel1 = tag_out1.valid && (tag_out1.tag == lat_tag);

    assign hit = sel0 | sel1;
    assign hit_way = sel1;  // a block lives in at most one way
    assign hit_block = sel1 ? data_out1 : data_out0;

    // word starting at the addressed byte, upper bytes zero near the block end
    assign rd_word = cache_pkg::word_t'(hit_block >> {lat_offset, 3'b000});

    // refill target: an empty way first, else the random way
    always_comb begin
        case ({tag_out1.valid, tag_out0.valid})
            2'b11: begin
                fill_way_we = {victim_bit, ~victim_bit};
            end
            2'b01: begin
                fill_way_we = 2'b10;
            end
            default: begin
                fill_way_we = 2'b01;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/store_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_merge (
    input wire cache_pkg::block_t hit_block,
    input wire cache_pkg::req_width_t req_width,
    input wire cache_pkg::offset_t offset,
    input wire cache_pkg::word_t wr_data,
    input wire mem_resp_valid,
    input wire cache_pkg::block_t mem_resp_block_data,
    output cache_pkg::block_t new_block
);

    localparam int n_lanes = $bits(cache_pkg::block_t) / 8;
    localparam int word_lanes = $bits(cache_pkg::word_t) / 8;

    localparam logic [n_lanes-1:0] byte_lanes = 'h1;
    localparam logic [n_lanes-1:0] half_lanes = 'h3;
    localparam logic [n_lanes-1:0] full_lanes = 'hf;

    logic [n_lanes-1:0] lane_mask;
    cache_pkg::block_t store_data;
    cache_pkg::block_t merged;

    // the store arrives aligned, so the data is repeated over the block
    // and the mask picks the addressed lanes
    always_comb begin
        case (req_width)
            cache_pkg::BYTE: begin
                lane_mask = byte_lanes << offset;
                store_data = {n_lanes{wr_data[7:0]}};
            end
            cache_pkg::HALFWORD: begin
                lane_mask = half_lanes << offset;
                store_data = {(n_lanes / 2){wr_data[15:0]}};
            end
            cache_pkg::WORD: begin
                lane_mask = full_lanes << offset;
                store_data = {(n_lanes / word_lanes){wr_data}};
            end
            default: begin
                lane_mask = '0;
                store_data = '0;
            end
        endcase
    end

    always_comb begin
        merged = hit_block;
        for (int i = 0; i < n_lanes; i++) begin
            if (lane_mask[i]) begin
                merged[8*i +: 8] = store_data[8*i +: 8];
            end
        end
    end

    assign new_block = mem_resp_valid ? mem_resp_block_data : merged; // refill wins

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input wire clk,
    input wire init,
    input wire req_valid,
    input wire cache_pkg::req_type_t req_type,
    input wire cache_pkg::req_width_t req_width,
    input wire cache_pkg::addr_t req_addr,
    input wire cache_pkg::word_t req_wr_data,
    input wire hit,
    input wire hit_way,
    input wire [1:0] fill_way_we,
    input wire mem_req_ready,
    input wire mem_resp_valid,
    output logic ram_read,
    output logic [1:0] tag_write,
    output logic [1:0] data_write,
    output cache_pkg::req_width_t lat_width,
    output cache_pkg::addr_t lat_addr,
    output cache_pkg::word_t lat_wr_data,
    output logic resp_valid,
    output logic mem_req_valid,
    output cache_pkg::req_type_t mem_req_type,
    output cache_pkg::block_addr_t mem_req_block_addr
);

    logic lat_valid;
    cache_pkg::req_type_t lat_type;
    logic was_valid;    // response already given to the held request
    logic refill_wait;  // READ accepted, block not back yet
    logic wt_pending;   // write-through still waiting for ready
    logic fill_done;    // cycle after a refill, lookup repeats
    logic hold;
    logic lookup_ok;
    logic miss_req;
    logic wt_req;
    logic mem_accept;

    // a waiting write-through keeps the RAM output and the latched store steady,
    // since both feed the merged block on mem_req_block_data
    assign hold = wt_pending & ~mem_req_ready;
    assign ram_read = req_valid & ~hold;

    assign lookup_ok = lat_valid & ~was_valid & ~refill_wait & ~fill_done & ~wt_pending;

    assign resp_valid = lookup_ok & hit;
    assign miss_req = lookup_ok & ~hit;
    assign wt_req = resp_valid & (lat_type == cache_pkg::WRITE);

    assign mem_req_valid = miss_req | wt_req | wt_pending;
    assign mem_req_type = miss_req ? cache_pkg::READ : cache_pkg::WRITE; // every miss refills first
    assign mem_req_block_addr = lat_addr[$bits(cache_pkg::addr_t)-1:cache_pkg::offset_bits];
    assign mem_accept = mem_req_valid & mem_req_ready;

    // refill writes tag and data into the chosen way, a store hit only the data
    assign tag_write = mem_resp_valid ? fill_way_we : 2'b00;

    always_comb begin
        if (mem_resp_valid) begin
            data_write = fill_way_we;
        end else if (wt_req) begin
            data_write = hit_way ? 2'b10 : 2'b01;
        end else begin
            data_write = 2'b00;
        end
    end

    // latched request, re-taken every lookup cycle
    always_ff @(posedge clk) begin
        if (!hold) begin
            lat_type <= req_type;
            lat_width <= req_width;
            lat_addr <= req_addr;
            lat_wr_data <= req_wr_data;
        end
    end

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            lat_valid <= 1'b0;
            was_valid <= 1'b0;
            refill_wait <= 1'b0;
            wt_pending <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            lat_valid <= req_valid;
            was_valid <= resp_valid;  // pipeline drops req_valid the cycle after
            fill_done <= mem_resp_valid;

            if (mem_accept && (mem_req_type == cache_pkg::READ)) begin
                refill_wait <= 1'b1;
            end else if (mem_resp_valid) begin
                refill_wait <= 1'b0;
            end

            if (mem_accept) begin
                wt_pending <= 1'b0;
            end else if (wt_req) begin
                wt_pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache (
    input wire clk,
    input wire init,
    input wire req_valid,
    input wire cache_pkg::req_type_t req_type,
    input wire cache_pkg::req_width_t req_width,
    input wire cache_pkg::addr_t req_addr,
    input wire cache_pkg::word_t req_wr_data,
    output logic resp_valid,
    output cache_pkg::word_t resp_rd_data,
    output logic mem_req_valid,
    output cache_pkg::req_type_t mem_req_type,
    output cache_pkg::block_addr_t mem_req_block_addr,
    output cache_pkg::block_t mem_req_block_data,
    input wire mem_req_ready,
    input wire mem_resp_valid,
    input wire cache_pkg::block_t mem_resp_block_data
);

    logic ram_read;
    logic [1:0] tag_write;
    logic [1:0] data_write;
    cache_pkg::req_width_t lat_width;
    cache_pkg::addr_t lat_addr;
    cache_pkg::word_t lat_wr_data;
    cache_pkg::tag_entry_t tag_out0;
    cache_pkg::tag_entry_t tag_out1;
    cache_pkg::block_t data_out0;
    cache_pkg::block_t data_out1;
    cache_pkg::block_t hit_block;
    logic hit;
    logic hit_way;
    logic victim_bit;
    logic [1:0] fill_way_we;

    cache_ctrl ctrl (
        .clk(clk),
        .init(init),
        .req_valid(req_valid),
        .req_type(req_type),
        .req_width(req_width),
        .req_addr(req_addr),
        .req_wr_data(req_wr_data),
        .hit(hit),
        .hit_way(hit_way),
        .fill_way_we(fill_way_we),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .ram_read(ram_read),
        .tag_write(tag_write),
        .data_write(data_write),
        .lat_width(lat_width),
        .lat_addr(lat_addr),
        .lat_wr_data(lat_wr_data),
        .resp_valid(resp_valid),
        .mem_req_valid(mem_req_valid),
        .mem_req_type(mem_req_type),
        .mem_req_block_addr(mem_req_block_addr)
    );

    // index comes from the live request, which the pipeline holds until resp_valid
    set_ram #(
        .entry_t(cache_pkg::tag_entry_t),
        .depth(`N_SETS)
    ) tag_ram (
        .clk(clk),
        .init(init),
        .en(ram_read),
        .index(req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits]),
        .way_we(tag_write),
        .din({1'b1, lat_addr[`ADDR_WIDTH-1 -: cache_pkg::tag_bits]}), // refilled entry
        .dout0(tag_out0),
        .dout1(tag_out1)
    );

    set_ram #(
        .entry_t(cache_pkg::block_t),
        .depth(`N_SETS)
    ) data_ram (
        .clk(clk),
        .init(init),
        .en(ram_read),
        .index(req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits]),
        .way_we(data_write),
        .din(mem_req_block_data),  // refill block or merged store
        .dout0(data_out0),
        .dout1(data_out1)
    );

    way_lfsr lfsr (
        .clk(clk),
        .init(init),
        .step(mem_resp_valid),
        .victim_bit(victim_bit)
    );

    way_match match (
        .lat_addr(lat_addr),
        .tag_out0(tag_out0),
        .tag_out1(tag_out1),
        .data_out0(data_out0),
        .data_out1(data_out1),
        .victim_bit(victim_bit),
        .hit(hit),
        .hit_way(hit_way),
        .hit_block(hit_block),
        .rd_word(resp_rd_data),
        .fill_way_we(fill_way_we)
    );

    store_merge merge (
        .hit_block(hit_block),
        .req_width(lat_width),
        .offset(lat_addr[cache_pkg::offset_bits-1:0]),
        .wr_data(lat_wr_data),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_block_data(mem_resp_block_data),
        .new_block(mem_req_block_data)
    );

endmodule

`default_nettype wire

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

// main memory behind the cache with 256 blocks aliased on the low block address bits
module mem_model (
    input wire clk,
    input wire init,
    input wire req_valid,
    input wire cache_pkg::req_type_t req_type,
    input wire cache_pkg::block_addr_t req_block_addr,
    input wire cache_pkg::block_t req_block_data,
    output logic req_ready,
    output logic resp_valid,
    output cache_pkg::block_t resp_block_data
);

    cache_pkg::block_t blocks [256];    // contents are loaded by the testbench

    logic busy;             // a READ is waiting for its response
    int delay;
    logic [7:0] rd_index;

    always @(posedge clk or posedge init) begin
        if (init) begin
            req_ready <= 1'b0;
            resp_valid <= 1'b0;
            resp_block_data <= '0;
            busy <= 1'b0;
            delay <= 0;
            rd_index <= '0;
        end else begin
            resp_valid <= 1'b0;
            req_ready <= ($urandom % 2) != 0; // random back-pressure

            if (req_valid && req_ready) begin
                if (req_type == cache_pkg::WRITE) begin
                    blocks[req_block_addr[7:0]] <= req_block_data;
                end else begin
                    busy <= 1'b1;
                    delay <= `MEM_LATENCY;
                    rd_index <= req_block_addr[7:0];
                end
            end

            if (busy) begin
                if (delay <= 1) begin
                    resp_valid <= 1'b1;
                    resp_block_data <= blocks[rd_index];
                    busy <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_dcache;

    localparam int n_requests = 91;                     // requests issued by all tests
    localparam int cycle_limit = 40 * n_requests + 20;  // plus reset and idle cycles

    logic clk;
    logic init;
    logic req_valid;
    cache_pkg::req_type_t req_type;
    cache_pkg::req_width_t req_width;
    cache_pkg::addr_t req_addr;
    cache_pkg::word_t req_wr_data;
    logic resp_valid;
    cache_pkg::word_t resp_rd_data;
    logic mem_req_valid;
    cache_pkg::req_type_t mem_req_type;
    cache_pkg::block_addr_t mem_req_block_addr;
    cache_pkg::block_t mem_req_block_data;
    logic mem_req_ready;
    logic mem_resp_valid;
    cache_pkg::block_t mem_resp_block_data;

    cache_pkg::block_t ref_mem [256];   // expected memory contents
    cache_pkg::req_type_t acc_type [$]; // memory requests accepted during one access
    cache_pkg::block_addr_t acc_addr [$];
    cache_pkg::block_t acc_data [$];
    int resp_count = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    dcache dcache_i (
        .clk(clk),
        .init(init),
        .req_valid(req_valid),
        .req_type(req_type),
        .req_width(req_width),
        .req_addr(req_addr),
        .req_wr_data(req_wr_data),
        .resp_valid(resp_valid),
        .resp_rd_data(resp_rd_data),
        .mem_req_valid(mem_req_valid),
        .mem_req_type(mem_req_type),
        .mem_req_block_addr(mem_req_block_addr),
        .mem_req_block_data(mem_req_block_data),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_block_data(mem_resp_block_data)
    );

    mem_model mem (
        .clk(clk),
        .init(init),
        .req_valid(mem_req_valid),
        .req_type(mem_req_type),
        .req_block_addr(mem_req_block_addr),
        .req_block_data(mem_req_block_data),
        .req_ready(mem_req_ready),
        .resp_valid(mem_resp_valid),
        .resp_block_data(mem_resp_block_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // record accepted memory requests and count responses
    always @(posedge clk) begin
        if (!init && mem_req_valid && mem_req_ready) begin
            acc_type.push_back(mem_req_type);
            acc_addr.push_back(mem_req_block_addr);
            acc_data.push_back(mem_req_block_data);
        end
        if (!init && resp_valid) begin
            resp_count++;
            checks++;
            assert (req_valid) else report_problem("monitor", "response without a request");
        end
    end

    task automatic report_value(input string name, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
    endtask

    task automatic report_problem(input string name, input string what);
        errors++;
        $display("error in %s: %s", name, what);
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // lanes offset and up take the low bytes of the store data
    function automatic cache_pkg::block_t merge_ref(input cache_pkg::block_t blk,
            input cache_pkg::req_width_t width, input logic [2:0] offset,
            input cache_pkg::word_t data);
        int n;
        n = (width == cache_pkg::BYTE) ? 1 : (width == cache_pkg::HALFWORD) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            blk[8*(offset+b) +: 8] = data[8*b +: 8];
        end
        return blk;
    endfunction

    function automatic cache_pkg::word_t word_at(input cache_pkg::block_t blk,
                                                 input logic [2:0] offset);
        cache_pkg::word_t w;
        w = '0;
        for (int b = 0; b < 4; b++) begin
            if (offset + b < 8) begin
                w[8*b +: 8] = blk[8*(offset+b) +: 8];
            end
        end
        return w;
    endfunction

    // one request where expect_hit is 1 for a hit, 0 for a miss and -1 when either is fine
    task automatic access(input string name, input cache_pkg::req_type_t typ,
                          input cache_pkg::req_width_t width, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t data, input int expect_hit);
        cache_pkg::block_addr_t baddr;
        cache_pkg::block_t merged;
        cache_pkg::word_t rd;
        logic [7:0] idx;
        int lat;
        int resp_before;
        int n_wt;
        baddr = addr[31:3];
        idx = baddr[7:0];
        n_wt = (typ == cache_pkg::WRITE) ? 1 : 0;
        merged = merge_ref(ref_mem[idx], width, addr[2:0], data);
        acc_type.delete();
        acc_addr.delete();
        acc_data.delete();
        resp_before = resp_count;
        req_valid <= 1'b1;
        req_type <= typ;
        req_width <= width;
        req_addr <= addr;
        req_wr_data <= data;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!resp_valid);
        lat = lat - 1; // cycles after the first request cycle
        rd = resp_rd_data;
        req_valid <= 1'b0;
        @(posedge clk);
        while (mem_req_valid) @(posedge clk); // let the write-through drain

        checks++;
        assert (resp_count - resp_before == 1)
            else report_problem(name, "response count per request is not one");
        if (expect_hit == 1) begin
            checks += 2;
            assert (lat == 1) else report_value(name, "latency", 1, lat);
            assert (acc_type.size() == n_wt)
                else report_problem(name, "a hit issued an extra memory request");
        end else if (expect_hit == 0) begin
            checks++;
            assert (acc_type.size() == n_wt + 1 && acc_type[0] == cache_pkg::READ &&
                    acc_addr[0] == baddr)
                else report_problem(name, "the miss did not issue exactly one READ of the block");
        end
        if (typ == cache_pkg::READ) begin
            checks++;
            assert (rd == word_at(ref_mem[idx], addr[2:0]))
                else report_value(name, "read data", word_at(ref_mem[idx], addr[2:0]), rd);
        end else begin
            checks++;
            assert (acc_type.size() > 0 && acc_type[$] == cache_pkg::WRITE &&
                    acc_addr[$] == baddr)
                else report_problem(name, "store was not written through to memory");
            if (acc_data.size() > 0) begin
                checks++;
                assert (acc_data[$] == merged)
                    else report_value(name, "written block", merged, acc_data[$]);
            end
            ref_mem[idx] = merged;
        end
    endtask

    initial begin
        cache_pkg::block_t v;
        int start;
        cache_pkg::addr_t a;
        cache_pkg::req_width_t w;
        void'($urandom(32'h761b));
        for (int i = 0; i < 256; i++) begin
            v = {$urandom, $urandom};
            mem.blocks[i] = v;
            ref_mem[i] = v;
        end
        init = 1'b1;
        req_valid = 1'b0;
        req_type = cache_pkg::READ;
        req_width = cache_pkg::WORD;
        req_addr = '0;
        req_wr_data = '0;
        repeat (4) @(posedge clk);
        init <= 1'b0;

        start = errors;
        repeat (6) begin
            @(posedge clk);
            checks++;
            assert (!resp_valid && !mem_req_valid)
                else report_problem("idle", "output active before any request");
        end
        close_test("idle", start);

        start = errors;
        access("read_miss", cache_pkg::READ, cache_pkg::WORD, 32'h240, 0, 0);
        access("read_hit", cache_pkg::READ, cache_pkg::WORD, 32'h244, 0, 1);
        close_test("read", start);

        start = errors;
        access("word_store", cache_pkg::WRITE, cache_pkg::WORD, 32'h244, 32'hcafe_f00d, 1);
        access("word_readback", cache_pkg::READ, cache_pkg::WORD, 32'h244, 0, 1);
        close_test("word_store", start);

        start = errors;
        access("lanes_fill", cache_pkg::READ, cache_pkg::WORD, 32'h2c8, 0, 0);
        for (int off = 0; off < 8; off++) begin
            access("byte_store", cache_pkg::WRITE, cache_pkg::BYTE, 32'h2c8 + off,
                   $urandom, 1);
            access("byte_readback", cache_pkg::READ, cache_pkg::WORD,
                   32'h2c8 + (off & 4), 0, 1);
        end
        for (int off = 0; off < 8; off += 2) begin
            access("half_store", cache_pkg::WRITE, cache_pkg::HALFWORD, 32'h2c8 + off,
                   $urandom, 1);
            access("half_readback", cache_pkg::READ, cache_pkg::WORD,
                   32'h2c8 + (off & 4), 0, 1);
        end
        close_test("lanes", start);

        start = errors;
        access("store_miss", cache_pkg::WRITE, cache_pkg::HALFWORD, 32'h356, 32'h1234, 0);
        access("store_miss_readback", cache_pkg::READ, cache_pkg::WORD, 32'h354, 0, 1);
        close_test("store_miss", start);

        // five tags on set 0 against two ways
        start = errors;
        repeat (60) begin
            a = ($urandom % 5) * 128;
            if ($urandom % 2) begin
                w = cache_pkg::req_width_t'($urandom % 3);
                if (w == cache_pkg::BYTE) begin
                    a = a + ($urandom % 8);
                end else if (w == cache_pkg::HALFWORD) begin
                    a = a + ($urandom % 4) * 2;
                end else begin
                    a = a + ($urandom % 2) * 4;
                end
                access("evict_store", cache_pkg::WRITE, w, a, $urandom, -1);
            end else begin
                a = a + ($urandom % 2) * 4;
                access("evict_read", cache_pkg::READ, cache_pkg::WORD, a, 0, -1);
            end
        end
        close_test("evict", start);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/cache_pkg.sv
hdl/set_ram.sv
hdl/way_lfsr.sv
hdl/way_match.sv
hdl/store_merge.sv
hdl/cache_ctrl.sv
hdl/dcache.sv
testbench/mem_model.sv
testbench/tb_dcache.sv
